// ==== Bender.yml ====
package:
  name: accelerator_matrix_transpose

sources:
  # Packages and interfaces first, then the RTL bottom up
  - hw/transpose_types_pkg.sv
  - hw/transpose_fsm_pkg.sv
  - hw/matrix_ifs.sv
  - hw/transpose_loader.sv
  - hw/transpose_buffer.sv
  - hw/transpose_streamer.sv
  - hw/accelerator_matrix_transpose.sv

  # Simulation only
  - target: test
    files:
      - test/accelerator_matrix_transpose_checker.sv
      - test/accelerator_matrix_transpose_tb.sv

// ==== files.f ====
hw/transpose_types_pkg.sv
hw/transpose_fsm_pkg.sv
hw/matrix_ifs.sv
hw/transpose_loader.sv
hw/transpose_buffer.sv
hw/transpose_streamer.sv
hw/accelerator_matrix_transpose.sv
test/accelerator_matrix_transpose_checker.sv
test/accelerator_matrix_transpose_tb.sv

// ==== hw/accelerator_matrix_transpose.sv ====
// Top level of the streaming matrix transpose accelerator, wires loader to streamer
`default_nettype none

module accelerator_matrix_transpose #(
  parameter int MAX_I = 8,
  parameter int MAX_J = 8
) (
  // Global
  input  logic                       CLK,
  input  logic                       RST,

  // Control
  input  logic                       start,
  output logic                       load_ready,
  output logic                       ready,

  // Input stream
  input  transpose_types_pkg::size_t size_i_in,
  input  transpose_types_pkg::size_t size_j_in,
  input  logic                       data_in_i_enable,
  input  logic                       data_in_j_enable,
  input  transpose_types_pkg::data_t data_in,

  // Output stream
  output logic                       data_out_i_enable,
  output logic                       data_out_j_enable,
  output transpose_types_pkg::data_t data_out
);

  matrix_write_if   wr_if ();
  matrix_read_if    rd_if ();
  matrix_handoff_if hs_if ();

  // Input side
  transpose_loader #(
    .MAX_I(MAX_I),
    .MAX_J(MAX_J)
  ) u_loader (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .size_i_in       (size_i_in),
    .size_j_in       (size_j_in),
    .data_in_i_enable(data_in_i_enable),
    .data_in_j_enable(data_in_j_enable),
    .data_in         (data_in),
    .load_ready      (load_ready),
    .wr              (wr_if.writer),
    .hs              (hs_if.producer)
  );

  // Banked storage
  transpose_buffer #(
    .MAX_I(MAX_I),
    .MAX_J(MAX_J)
  ) u_buffer (
    .CLK(CLK),
    .RST(RST),
    .wr (wr_if.memory),
    .rd (rd_if.memory)
  );

  // Output side
  transpose_streamer u_streamer (
    .CLK              (CLK),
    .RST              (RST),
    .hs               (hs_if.consumer),
    .rd               (rd_if.reader),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .data_out         (data_out)
  );

endmodule

`default_nettype wire

// ==== hw/matrix_ifs.sv ====
// Interfaces between loader, two-bank buffer and streamer of the transpose core
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Buffer write port
////////////////////////////////////////////////////////////////////////////

interface matrix_write_if;
  // One write per cycle while wr_en is high
  logic                        wr_en;
  logic                        wr_bank;
  transpose_types_pkg::index_t wr_row;
  transpose_types_pkg::index_t wr_col;
  transpose_types_pkg::data_t  wr_data;

  modport writer (output wr_en, wr_bank, wr_row, wr_col, wr_data);
  modport memory (input wr_en, wr_bank, wr_row, wr_col, wr_data);
endinterface

////////////////////////////////////////////////////////////////////////////
// Buffer read port
////////////////////////////////////////////////////////////////////////////

interface matrix_read_if;
  // Request side
  logic                        rd_en;
  logic                        rd_bank;
  transpose_types_pkg::index_t rd_row;
  transpose_types_pkg::index_t rd_col;
  // Returned one clock after rd_en
  transpose_types_pkg::data_t  rd_data;

  modport reader (output rd_en, rd_bank, rd_row, rd_col, input rd_data);
  modport memory (input rd_en, rd_bank, rd_row, rd_col, output rd_data);
endinterface

////////////////////////////////////////////////////////////////////////////
// Bank handoff, loader to streamer
////////////////////////////////////////////////////////////////////////////

interface matrix_handoff_if;
  // Bank and sizes held stable while full is high
  logic                       full;
  logic                       bank;
  transpose_types_pkg::size_t size_i;
  transpose_types_pkg::size_t size_j;
  // Single-cycle acknowledge, full drops on the next edge
  logic                       take;

  modport producer (output full, bank, size_i, size_j, input take);
  modport consumer (input full, bank, size_i, size_j, output take);
endinterface

`default_nettype wire

// ==== hw/transpose_buffer.sv ====
// Two-bank element memory of the transpose core with one write and one read port
`default_nettype none

module transpose_buffer #(
  parameter int MAX_I = 8,
  parameter int MAX_J = 8
) (
  input  logic           CLK,
  input  logic           RST,
  matrix_write_if.memory wr,
  matrix_read_if.memory  rd
);

  localparam int BANK_WORDS = MAX_I * MAX_J;
  localparam int DEPTH      = 2 * BANK_WORDS;
  localparam int ADDR_W     = $clog2(DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;

  transpose_types_pkg::data_t mem [DEPTH];
  addr_t                      wr_addr;
  addr_t                      rd_addr;
  transpose_types_pkg::data_t rd_q;
  transpose_types_pkg::data_t byp_data_q;
  logic                       byp_q;

  // Bank base plus row-major offset inside the bank
  function automatic addr_t addr_of(input logic bank,
                                    input transpose_types_pkg::index_t row,
                                    input transpose_types_pkg::index_t col);
    addr_of = addr_t'(bank) * addr_t'(BANK_WORDS) +
              addr_t'(row) * addr_t'(MAX_J) + addr_t'(col);
  endfunction

  always_comb begin
    wr_addr = addr_of(wr.wr_bank, wr.wr_row, wr.wr_col);
    rd_addr = addr_of(rd.rd_bank, rd.rd_row, rd.rd_col);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wr.wr_en) begin
      mem[wr_addr] <= wr.wr_data;
    end
    // Read data held until the next read
    if (rd.rd_en) begin
      rd_q       <= mem[rd_addr];
      byp_data_q <= wr.wr_data;
    end
  end

  // Same-address collision
  // happens for a 1x1 matrix, read issued in the cycle its only write lands
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      byp_q <= 1'b0;
    end else if (rd.rd_en) begin
      byp_q <= wr.wr_en && (wr_addr == rd_addr);
    end
  end

  // Write-first on collision, otherwise plain memory output
  assign rd.rd_data = byp_q ? byp_data_q : rd_q;

endmodule

`default_nettype wire

// ==== hw/transpose_fsm_pkg.sv ====
// State encodings of the loader and streamer FSMs in the transpose accelerator
`default_nettype none

package transpose_fsm_pkg;

  // Input side
  // IDLE waits for start, FILL counts elements, HANDOFF holds a full bank
  typedef enum logic [1:0] {
    LOAD_IDLE    = 2'd0,
    LOAD_FILL    = 2'd1,
    LOAD_HANDOFF = 2'd2
  } load_state_e;

  // Output side
  // READ issues one buffer read per clock, DRAIN lets the pipeline empty
  typedef enum logic [1:0] {
    STREAM_IDLE  = 2'd0,
    STREAM_READ  = 2'd1,
    STREAM_DRAIN = 2'd2
  } stream_state_e;

endpackage

`default_nettype wire

// ==== hw/transpose_loader.sv ====
// Input side of the transpose core; counts incoming elements and fills one bank
`default_nettype none

module transpose_loader #(
  parameter int MAX_I = 8,
  parameter int MAX_J = 8
) (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start,
  input  transpose_types_pkg::size_t size_i_in,
  input  transpose_types_pkg::size_t size_j_in,
  input  logic                       data_in_i_enable,
  input  logic                       data_in_j_enable,
  input  transpose_types_pkg::data_t data_in,
  output logic                       load_ready,
  matrix_write_if.writer             wr,
  matrix_handoff_if.producer         hs
);

  transpose_fsm_pkg::load_state_e state_q;
  logic                           bank_q;
  transpose_types_pkg::size_t     size_i_q;
  transpose_types_pkg::size_t     size_j_q;
  transpose_types_pkg::index_t    row_q;
  transpose_types_pkg::index_t    col_q;
  transpose_types_pkg::index_t    elem_row;
  transpose_types_pkg::index_t    elem_col;
  logic                           accept;
  logic                           elem_last;
  logic                           in_bounds;
  logic                           wr_en_q;
  logic                           wr_bank_q;
  transpose_types_pkg::index_t    wr_row_q;
  transpose_types_pkg::index_t    wr_col_q;
  transpose_types_pkg::data_t     wr_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Element position
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Also high in the take cycle, so a new load can start right away
    load_ready = (state_q == transpose_fsm_pkg::LOAD_IDLE) ||
                 (state_q == transpose_fsm_pkg::LOAD_HANDOFF && hs.take);
    accept = start && load_ready;
    // Row strobe opens a new row at column zero
    if (data_in_i_enable) begin
      elem_row = row_q + 1'b1;
      elem_col = '0;
    end else begin
      elem_row = row_q;
      elem_col = col_q;
    end
    elem_last = ({1'b0, elem_row} == size_i_q - 1'b1) &&
                ({1'b0, elem_col} == size_j_q - 1'b1);
    // Stray elements must not spill into the bank being streamed
    in_bounds = (int'(elem_row) < MAX_I) && (int'(elem_col) < MAX_J);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q  <= transpose_fsm_pkg::LOAD_IDLE;
      bank_q   <= 1'b0;
      size_i_q <= '0;
      size_j_q <= '0;
      row_q    <= '1;
      col_q    <= '0;
    end else begin
      // Streamer owns the full bank now, fill the other one next
      if (state_q == transpose_fsm_pkg::LOAD_HANDOFF && hs.take) begin
        bank_q <= ~bank_q;
      end
      case (state_q)
        transpose_fsm_pkg::LOAD_IDLE, transpose_fsm_pkg::LOAD_HANDOFF: begin
          if (accept) begin
            size_i_q <= size_i_in;
            size_j_q <= size_j_in;
            // First row strobe wraps this to row 0
            row_q    <= '1;
            col_q    <= '0;
            state_q  <= transpose_fsm_pkg::LOAD_FILL;
          end else if (hs.take) begin
            state_q <= transpose_fsm_pkg::LOAD_IDLE;
          end
        end
        transpose_fsm_pkg::LOAD_FILL: begin
          if (data_in_j_enable) begin
            row_q <= elem_row;
            col_q <= elem_col + 1'b1;
            if (elem_last) begin
              state_q <= transpose_fsm_pkg::LOAD_HANDOFF;
            end
          end
        end
        default: state_q <= transpose_fsm_pkg::LOAD_IDLE;
      endcase
    end
  end

  // Write stage, one clock behind the input strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= (state_q == transpose_fsm_pkg::LOAD_FILL) && data_in_j_enable && in_bounds;
    end
  end

  always_ff @(posedge CLK) begin
    wr_bank_q <= bank_q;
    wr_row_q  <= elem_row;
    wr_col_q  <= elem_col;
    wr_data_q <= data_in;
  end

  assign wr.wr_en   = wr_en_q;
  assign wr.wr_bank = wr_bank_q;
  assign wr.wr_row  = wr_row_q;
  assign wr.wr_col  = wr_col_q;
  assign wr.wr_data = wr_data_q;

  // Handoff offer
  assign hs.full   = (state_q == transpose_fsm_pkg::LOAD_HANDOFF);
  assign hs.bank   = bank_q;
  assign hs.size_i = size_i_q;
  assign hs.size_j = size_j_q;

endmodule

`default_nettype wire

// ==== hw/transpose_streamer.sv ====
// Output side of the transpose core; reads a full bank column by column
`default_nettype none

module transpose_streamer (
  input  logic                       CLK,
  input  logic                       RST,
  matrix_handoff_if.consumer         hs,
  matrix_read_if.reader              rd,
  output logic                       ready,
  output logic                       data_out_i_enable,
  output logic                       data_out_j_enable,
  output transpose_types_pkg::data_t data_out
);

  transpose_fsm_pkg::stream_state_e state_q;
  logic                             bank_q;
  transpose_types_pkg::size_t       size_i_q;
  transpose_types_pkg::size_t       size_j_q;
  transpose_types_pkg::size_t       cur_size_i;
  transpose_types_pkg::size_t       cur_size_j;
  transpose_types_pkg::index_t      row_q;
  transpose_types_pkg::index_t      col_q;
  logic                             idle;
  logic                             take;
  logic                             issue;
  logic                             row_last;
  logic                             col_last;
  logic                             last_rd;
  logic                             valid_q;
  logic                             first_q;
  logic                             last_q;
  logic                             last_out_q;

  ////////////////////////////////////////////////////////////////////////////
  // Read address generation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    idle = (state_q == transpose_fsm_pkg::STREAM_IDLE);
    take = idle && hs.full;
    // Sizes come straight from the handoff in the take cycle
    cur_size_i = idle ? hs.size_i : size_i_q;
    cur_size_j = idle ? hs.size_j : size_j_q;
    // First read goes out in the take cycle itself
    issue    = take || (state_q == transpose_fsm_pkg::STREAM_READ);
    row_last = ({1'b0, row_q} == cur_size_i - 1'b1);
    col_last = ({1'b0, col_q} == cur_size_j - 1'b1);
    last_rd  = issue && row_last && col_last;
  end

  assign hs.take    = take;
  assign rd.rd_en   = issue;
  assign rd.rd_bank = idle ? hs.bank : bank_q;
  assign rd.rd_row  = row_q;
  assign rd.rd_col  = col_q;

  ////////////////////////////////////////////////////////////////////////////
  // Stream FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q  <= transpose_fsm_pkg::STREAM_IDLE;
      bank_q   <= 1'b0;
      size_i_q <= '0;
      size_j_q <= '0;
      row_q    <= '0;
      col_q    <= '0;
    end else begin
      if (take) begin
        bank_q   <= hs.bank;
        size_i_q <= hs.size_i;
        size_j_q <= hs.size_j;
      end
      // Input row is the inner loop, input column the outer
      if (issue) begin
        if (row_last) begin
          row_q <= '0;
          col_q <= col_last ? '0 : col_q + 1'b1;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
      case (state_q)
        transpose_fsm_pkg::STREAM_IDLE: begin
          if (take) begin
            state_q <= last_rd ? transpose_fsm_pkg::STREAM_DRAIN :
                                 transpose_fsm_pkg::STREAM_READ;
          end
        end
        transpose_fsm_pkg::STREAM_READ: begin
          if (last_rd) begin
            state_q <= transpose_fsm_pkg::STREAM_DRAIN;
          end
        end
        transpose_fsm_pkg::STREAM_DRAIN: begin
          // Back to idle in the cycle ready pulses
          if (last_out_q) begin
            state_q <= transpose_fsm_pkg::STREAM_IDLE;
          end
        end
        default: state_q <= transpose_fsm_pkg::STREAM_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output pipeline
  ////////////////////////////////////////////////////////////////////////////

  // Stage 1 lines up with rd_data, stage 2 is the output register
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_q           <= 1'b0;
      first_q           <= 1'b0;
      last_q            <= 1'b0;
      data_out_j_enable <= 1'b0;
      data_out_i_enable <= 1'b0;
      last_out_q        <= 1'b0;
      ready             <= 1'b0;
    end else begin
      valid_q           <= issue;
      // Input row 0 starts each output row
      first_q           <= issue && (row_q == '0);
      last_q            <= last_rd;
      data_out_j_enable <= valid_q;
      data_out_i_enable <= first_q;
      last_out_q        <= last_q;
      ready             <= last_out_q;
    end
  end

  always_ff @(posedge CLK) begin
    if (valid_q) begin
      data_out <= rd.rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/transpose_types_pkg.sv ====
// Element, index and size widths shared by the transpose RTL and its testbench
`default_nettype none

package transpose_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Element data
  ////////////////////////////////////////////////////////////////////////////

  // Width of one matrix element
  parameter int DATA_W = 32;

  typedef logic [DATA_W-1:0] data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Indices and dimensions
  ////////////////////////////////////////////////////////////////////////////

  // Row or column position inside a bank, caps MAX_I and MAX_J at 256
  parameter int INDEX_W = 8;

  // One extra bit so a full 256 still fits as a dimension
  parameter int SIZE_W = INDEX_W + 1;

  typedef logic [INDEX_W-1:0] index_t;

  // Matrix dimension, 1 up to MAX_I or MAX_J
  typedef logic [SIZE_W-1:0] size_t;

endpackage

`default_nettype wire

// ==== test/accelerator_matrix_transpose_checker.sv ====
// Protocol and size assertions for the transpose accelerator, bound to its top level
`default_nettype none

module accelerator_matrix_transpose_checker #(
  parameter int MAX_I = 8,
  parameter int MAX_J = 8
) (
  input logic                       CLK,
  input logic                       RST,
  input logic                       start,
  input logic                       load_ready,
  input transpose_types_pkg::size_t size_i_in,
  input transpose_types_pkg::size_t size_j_in,
  input logic                       ready,
  input logic                       data_out_i_enable,
  input logic                       data_out_j_enable,
  input logic                       full,
  input logic                       take
);

  // Running total of assertion failures
  int fail_count = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Host side
  ////////////////////////////////////////////////////////////////////////////

  // Accepted start must carry dimensions the banks can hold
  a_size_range: assert property (
    @(posedge CLK) disable iff (RST)
    (start && load_ready) |->
      (int'(size_i_in) >= 1 && int'(size_i_in) <= MAX_I &&
       int'(size_j_in) >= 1 && int'(size_j_in) <= MAX_J)
  ) else begin
    $error("start accepted with sizes outside the bank capacity");
    fail_count++;
  end

  // Done pulse, never two cycles long
  a_ready_pulse: assert property (
    @(posedge CLK) disable iff (RST)
    ready |=> !ready
  ) else begin
    $error("ready held for more than one cycle");
    fail_count++;
  end

  // Row strobe only rides on an element strobe
  a_row_with_elem: assert property (
    @(posedge CLK) disable iff (RST)
    data_out_i_enable |-> data_out_j_enable
  ) else begin
    $error("data_out_i_enable without data_out_j_enable");
    fail_count++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Internal handoff
  ////////////////////////////////////////////////////////////////////////////

  a_take_full: assert property (
    @(posedge CLK) disable iff (RST)
    take |-> full
  ) else begin
    $error("handoff take while no bank is full");
    fail_count++;
  end

endmodule

`default_nettype wire

// ==== test/accelerator_matrix_transpose_tb.sv ====
// Testbench for the transpose accelerator; loads matrices from the data file, checks transposes
`default_nettype none

module accelerator_matrix_transpose_tb;

  localparam int MAX_I = 8;
  localparam int MAX_J = 8;
  localparam int WORDS = 512;

  logic                       CLK;
  logic                       RST;
  logic                       start;
  transpose_types_pkg::size_t size_i_in;
  transpose_types_pkg::size_t size_j_in;
  logic                       data_in_i_enable;
  logic                       data_in_j_enable;
  transpose_types_pkg::data_t data_in;
  logic                       load_ready;
  logic                       ready;
  logic                       data_out_i_enable;
  logic                       data_out_j_enable;
  transpose_types_pkg::data_t data_out;

  // Data file image and one descriptor per matrix
  transpose_types_pkg::data_t words [WORDS];
  int                         mat_base [$];
  int                         mat_si [$];
  int                         mat_sj [$];
  int                         mat_gap [$];

  // Expected output, queued per matrix
  transpose_types_pkg::data_t exp_q [$];
  int                         exp_si_q [$];
  int                         exp_sj_q [$];

  int   seed = 91819;
  int   cycles;
  int   cycle_limit;
  int   mats_done;
  // Monitor state
  logic active;
  int   cur_si;
  int   cur_sj;
  int   out_cnt;

  accelerator_matrix_transpose #(
    .MAX_I(MAX_I),
    .MAX_J(MAX_J)
  ) u_dut (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .load_ready       (load_ready),
    .ready            (ready),
    .size_i_in        (size_i_in),
    .size_j_in        (size_j_in),
    .data_in_i_enable (data_in_i_enable),
    .data_in_j_enable (data_in_j_enable),
    .data_in          (data_in),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .data_out         (data_out)
  );

  bind accelerator_matrix_transpose accelerator_matrix_transpose_checker #(
    .MAX_I(MAX_I),
    .MAX_J(MAX_J)
  ) u_checker (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .load_ready       (load_ready),
    .size_i_in        (size_i_in),
    .size_j_in        (size_j_in),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .full             (hs_if.full),
    .take             (hs_if.take)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Error handling and compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input transpose_types_pkg::data_t got,
                            input transpose_types_pkg::data_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("FAIL @%0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_strobe(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("FAIL @%0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input transpose_types_pkg::size_t got,
                             input transpose_types_pkg::size_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("FAIL @%0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock and cycle limit
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    // Limit stays zero until the data file is scanned
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      stop_run($sformatf("Timeout after %0d cycles, the DUT did not finish all matrices",
                         cycles));
    end
  end

  // Bound checker failures end the run as well
  always @(negedge CLK) begin
    if (u_dut.u_checker.fail_count != 0) begin
      stop_run("A protocol assertion in the bound checker failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge CLK) begin
    if (!RST) begin
      if (ready) begin
        // Done pulse closes the matrix in flight
        if (!active) begin
          stop_run("ready pulsed while no matrix was streaming out");
        end
        check_count(transpose_types_pkg::size_t'(out_cnt),
                    transpose_types_pkg::size_t'(cur_si * cur_sj),
                    "output elements before ready");
        active = 1'b0;
        mats_done++;
      end else if (active && out_cnt == cur_si * cur_sj) begin
        // Stream complete, done pulse due now
        check_strobe(ready, 1'b1, "ready after last element");
      end
      // No gaps once a matrix has started
      if (active) begin
        check_strobe(data_out_j_enable, 1'b1, "gapless output strobe");
      end
      if (data_out_j_enable) begin
        if (!active) begin
          if (exp_si_q.size() == 0) begin
            stop_run("An output element appeared while no matrix had been loaded");
          end
          cur_si   = exp_si_q.pop_front();
          cur_sj   = exp_sj_q.pop_front();
          active   = 1'b1;
          out_cnt  = 0;
        end
        // Output rows are size_i long
        check_strobe(data_out_i_enable, (out_cnt % cur_si) == 0, "output row strobe");
        check_data(data_out, exp_q.pop_front(), "output element");
        out_cnt++;
      end else begin
        check_strobe(data_out_i_enable, 1'b0, "row strobe without element strobe");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Called and returns on a falling edge
  task automatic load_matrix(input int m);
    int si;
    int sj;
    int base;
    int idle;
    si   = mat_si[m];
    sj   = mat_sj[m];
    base = mat_base[m];
    // Output (r,c) is input (c,r)
    for (int r = 0; r < sj; r++) begin
      for (int c = 0; c < si; c++) begin
        exp_q.push_back(words[base + c * sj + r]);
      end
    end
    exp_si_q.push_back(si);
    exp_sj_q.push_back(sj);
    // Start as soon as the loader frees up
    while (load_ready !== 1'b1) begin
      @(negedge CLK);
    end
    start     = 1'b1;
    size_i_in = transpose_types_pkg::size_t'(si);
    size_j_in = transpose_types_pkg::size_t'(sj);
    @(negedge CLK);
    start = 1'b0;
    // Loader busy until its bank is handed off
    check_strobe(load_ready, 1'b0, "load_ready during load");
    for (int r = 0; r < si; r++) begin
      for (int c = 0; c < sj; c++) begin
        if (mat_gap[m] != 0) begin
          idle = $unsigned($random(seed)) % 4;
          repeat (idle) @(negedge CLK);
        end
        data_in_j_enable = 1'b1;
        data_in_i_enable = (c == 0);
        data_in          = words[base + r * sj + c];
        @(negedge CLK);
        data_in_j_enable = 1'b0;
        data_in_i_enable = 1'b0;
      end
    end
  endtask

  initial begin
    int idx;
    int si;
    int sj;
    int sum;
    start            = 1'b0;
    size_i_in        = '0;
    size_j_in        = '0;
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    data_in          = '0;
    RST              = 1'b1;
    active           = 1'b0;
    mats_done        = 0;
    cycles           = 0;
    cycle_limit      = 0;

    // Scan the blocks, a zero size_i ends the list
    $readmemh("test/transpose_testdata.txt", words);
    idx = 0;
    sum = 0;
    while (idx < WORDS && words[idx] !== '0) begin
      if (words[idx] === 'x) begin
        stop_run("The data file ended without the terminating zero");
      end
      si = int'(words[idx]);
      sj = int'(words[idx + 1]);
      if (si < 1 || si > MAX_I || sj < 1 || sj > MAX_J) begin
        stop_run($sformatf("The data file holds an out-of-range size %0dx%0d", si, sj));
      end
      mat_si.push_back(si);
      mat_sj.push_back(sj);
      mat_gap.push_back(int'(words[idx + 2]));
      mat_base.push_back(idx + 3);
      sum += 2 * si * sj + 10;
      idx += 3 + si * sj;
    end
    cycle_limit = 2 * sum + 100;

    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Quiet after reset, monitor covers ready and output strobes
    repeat (4) begin
      @(negedge CLK);
      check_strobe(load_ready, 1'b1, "load_ready after reset");
    end

    for (int m = 0; m < mat_si.size(); m++) begin
      load_matrix(m);
    end
    while (mats_done < mat_si.size()) begin
      @(negedge CLK);
    end
    // Idle tail, no stray ready or output
    repeat (6) @(negedge CLK);
    // Past the monitor sample of the last falling edge
    #1;
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/transpose_testdata.txt ====
// Blocks: size_i size_j gap_flag, then size_i rows of size_j elements, all hex
// A size_i of 0 ends the list
// 4x4 square
4 4 0
11000000 11000001 11000002 11000003
11000010 11000011 11000012 11000013
11000020 11000021 11000022 11000023
11000030 11000031 11000032 11000033
// 3x5
3 5 0
22000000 22000001 22000002 22000003 22000004
22000010 22000011 22000012 22000013 22000014
22000020 22000021 22000022 22000023 22000024
// 1x8 single row
1 8 0
33000000 33000001 33000002 33000003 33000004 33000005 33000006 33000007
// 8x1 single column
8 1 0
44000000
44000010
44000020
44000030
44000040
44000050
44000060
44000070
// 5x3 with random input gaps
5 3 1
55000000 55000001 55000002
55000010 55000011 55000012
55000020 55000021 55000022
55000030 55000031 55000032
55000040 55000041 55000042
// 1x1 with gaps
1 1 1
66c0ffee
0
